// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = mem_rdwr_tb
FILELIST = sim.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

# The verdict comes from the log, so a failing run makes grep fail
run: compile
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -qx "Simulation passed" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// ==== bench/mem_rdwr_tests.svh ====
`ifndef MEM_RDWR_TESTS_SVH
`define MEM_RDWR_TESTS_SVH

// Byte-enabled write into the scoreboard memory
function automatic void model_write(input int addr, input logic [DATA_WIDTH-1:0] data,
                                    input logic [BE_WIDTH-1:0] be);
    for (int b = 0; b < BE_WIDTH; b++)
    begin
        if (be[b])
            model_mem[addr[MEM_IDX_W-1:0]][8*b +: 8] = data[8*b +: 8];
    end
endfunction

// Called 1 ns after a rising edge; returns 1 ns after the edge that took the beat
task automatic wait_rd_accept();
    logic taken;
    taken = 1'b0;
    while (!taken)
    begin
        @(negedge clk);
        taken = !host_rd_waitrequest;
        @(posedge clk);
        #1;
    end
endtask

task automatic wait_wr_accept();
    logic taken;
    taken = 1'b0;
    while (!taken)
    begin
        @(negedge clk);
        taken = !host_wr_waitrequest;
        @(posedge clk);
        #1;
    end
endtask

// Waits until every expected response came back, then for a quiet stretch
task automatic wait_responses();
    while (exp_rd_q.size() != 0 || exp_wr_q.size() != 0)
        @(posedge clk);
    repeat (QUIET_CYCLES) @(posedge clk);
    #1;
endtask

// One read request of len beats; expected beats are queued from the model first
task automatic read_burst(input int addr, input int len, input int tag);
    rd_rsp_t exp;
    int a;
    for (int i = 0; i < len; i++)
    begin
        a = addr + i;
        exp.readdatavalid = 1'b1;
        exp.readresponseuser = USER_WIDTH'(tag);
        exp.readdata = (a < MEM_DEPTH) ? model_mem[a[MEM_IDX_W-1:0]] : '0;
        exp.response = (a < MEM_DEPTH) ? RSP_OKAY : RSP_SLVERR;
        exp_rd_q.push_back(exp);
    end
    host_rd_req.read = 1'b1;
    host_rd_req.address = ADDR_WIDTH'(addr);
    host_rd_req.burstcount = BURST_WIDTH'(len);
    host_rd_req.byteenable = '1;
    host_rd_req.user = USER_WIDTH'(tag);
    wait_rd_accept();
    host_rd_req.read = 1'b0;
endtask

// A write burst of len random beats; any beat past the end makes it SLVERR
task automatic write_burst(input int addr, input int len, input int tag,
                           input bit random_be);
    wr_rsp_t exp;
    logic [DATA_WIDTH-1:0] data;
    logic [BE_WIDTH-1:0] be;
    exp.writeresponsevalid = 1'b1;
    exp.writeresponseuser = USER_WIDTH'(tag);
    exp.response = (addr + len > MEM_DEPTH) ? RSP_SLVERR : RSP_OKAY;
    exp_wr_q.push_back(exp);
    host_wr_req.write = 1'b1;
    host_wr_req.address = ADDR_WIDTH'(addr);
    host_wr_req.burstcount = BURST_WIDTH'(len);
    host_wr_req.user = USER_WIDTH'(tag);
    for (int i = 0; i < len; i++)
    begin
        data = DATA_WIDTH'($random(seed));
        be = random_be ? BE_WIDTH'($random(seed)) : '1;
        if (addr + i < MEM_DEPTH)
            model_write(addr + i, data, be);
        host_wr_req.writedata = data;
        host_wr_req.byteenable = be;
        wait_wr_accept();
    end
    host_wr_req.write = 1'b0;
endtask

task automatic check_after_reset();
    check_value("host_rd_waitrequest", '0, DATA_WIDTH'(host_rd_waitrequest));
    check_value("host_wr_waitrequest", '0, DATA_WIDTH'(host_wr_waitrequest));
    check_value("host_rd_rsp.readdatavalid", '0, DATA_WIDTH'(host_rd_rsp.readdatavalid));
    check_value("host_wr_rsp.writeresponsevalid", '0,
                DATA_WIDTH'(host_wr_rsp.writeresponsevalid));
endtask

task automatic test_single_beat();
    write_burst(10, 1, 3, 1'b0);
    wait_responses();
    read_burst(10, 1, 5);
    wait_responses();
endtask

// Full words first, so the later partial writes never leave unknown bytes
task automatic test_bursts();
    for (int i = 0; i < 4; i++)
        write_burst(32 + 4 * i, 4, i, 1'b0);
    wait_responses();
    for (int len = 1; len <= 4; len++)
        write_burst(32 + 4 * (len - 1), len, len + 4, 1'b1);
    wait_responses();
    for (int len = 1; len <= 4; len++)
        read_burst(32 + 4 * (len - 1), len, len + 8);
    for (int i = 0; i < 4; i++)
        read_burst(32 + 4 * i, 4, i + 12);
    wait_responses();
endtask

// Address 500 aliases word 244 in the low bits, which must stay untouched
task automatic test_out_of_range();
    write_burst(244, 1, 1, 1'b0);
    write_burst(254, 2, 2, 1'b0);
    wait_responses();
    write_burst(500, 2, 3, 1'b1);
    write_burst(254, 4, 4, 1'b0);
    write_burst(1000, 1, 5, 1'b0);
    wait_responses();
    read_burst(300, 2, 6);
    read_burst(254, 4, 7);
    read_burst(244, 1, 8);
    wait_responses();
endtask

// Both channels at once on separate regions, then the written region read back
task automatic test_concurrent();
    fork
        begin
            for (int i = 0; i < 4; i++)
                write_burst(64 + 4 * i, 4, i, 1'b0);
        end
        begin
            for (int i = 0; i < 4; i++)
                read_burst(32 + 4 * i, 4, i + 8);
        end
    join
    wait_responses();
    for (int i = 0; i < 4; i++)
        read_burst(64 + 4 * i, 4, i);
    wait_responses();
endtask

// Back to back single beats pile up behind bursts on the other channel
task automatic test_back_pressure();
    fork
        begin
            for (int i = 0; i < 4; i++)
                write_burst(96 + 4 * i, 4, i, 1'b0);
        end
        begin
            for (int i = 0; i < 8; i++)
                read_burst(64 + i, 1, i);
        end
    join
    wait_responses();
    fork
        begin
            for (int i = 0; i < 4; i++)
                read_burst(96 + 4 * i, 4, i + 4);
        end
        begin
            for (int i = 0; i < 6; i++)
                write_burst(112 + i, 1, i + 8, 1'b0);
        end
    join
    wait_responses();
    read_burst(112, 4, 14);
    read_burst(116, 2, 15);
    wait_responses();
endtask

`endif

// ==== bench/mem_rdwr_tb.sv ====
`timescale 1ns/10ps

// Directed testbench for the split read/write memory path.
// A scoreboard array mirrors the memory and every response is checked in order
module mem_rdwr_tb;

    import mem_rdwr_pkg::*;

    // Index width of the scoreboard array
    localparam int MEM_IDX_W = $clog2(MEM_DEPTH);

    // The directed tests take around a thousand cycles, so this is about four times that
    localparam int MAX_CYCLES = 4000;

    // Idle cycles that must pass without a stray response once all expected ones arrived
    localparam int QUIET_CYCLES = 8;

    logic    clk;
    logic    reset;
    rd_req_t host_rd_req;
    logic    host_rd_waitrequest;
    rd_rsp_t host_rd_rsp;
    wr_req_t host_wr_req;
    logic    host_wr_waitrequest;
    wr_rsp_t host_wr_rsp;

    integer seed;
    int     cycle_count;

    // Scoreboard memory, plus the responses still owed by the DUT, oldest first
    logic [DATA_WIDTH-1:0] model_mem [MEM_DEPTH];
    rd_rsp_t exp_rd_q [$];
    wr_rsp_t exp_wr_q [$];

    mem_rdwr_top uut
    (
        .clk(clk),
        .reset(reset),
        .host_rd_req(host_rd_req),
        .host_rd_waitrequest(host_rd_waitrequest),
        .host_rd_rsp(host_rd_rsp),
        .host_wr_req(host_wr_req),
        .host_wr_waitrequest(host_wr_waitrequest),
        .host_wr_rsp(host_wr_rsp)
    );

    initial
    begin
        clk = 1'b0;
        forever
            #5 clk = ~clk;
    end

    task automatic end_with_failure();
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [DATA_WIDTH-1:0] expected,
                               input logic [DATA_WIDTH-1:0] actual);
        if (actual !== expected)
        begin
            $display("[ERROR] time %0t: %s expected %h, got %h",
                     $time, name, expected, actual);
            end_with_failure();
        end
    endtask

    // Every read beat must match the oldest outstanding expectation
    task automatic compare_rd_rsp(input rd_rsp_t got);
        rd_rsp_t exp;
        if (exp_rd_q.size() == 0)
        begin
            $display("A read response arrived while no read beat was outstanding");
            end_with_failure();
        end
        else
        begin
            exp = exp_rd_q.pop_front();
            check_value("host_rd_rsp.readdata", exp.readdata, got.readdata);
            check_value("host_rd_rsp.response", DATA_WIDTH'(exp.response),
                        DATA_WIDTH'(got.response));
            check_value("host_rd_rsp.readresponseuser", DATA_WIDTH'(exp.readresponseuser),
                        DATA_WIDTH'(got.readresponseuser));
        end
    endtask

    // A write response with nothing outstanding means a duplicated burst
    task automatic compare_wr_rsp(input wr_rsp_t got);
        wr_rsp_t exp;
        if (exp_wr_q.size() == 0)
        begin
            $display("A write response arrived while no write burst was outstanding");
            end_with_failure();
        end
        else
        begin
            exp = exp_wr_q.pop_front();
            check_value("host_wr_rsp.response", DATA_WIDTH'(exp.response),
                        DATA_WIDTH'(got.response));
            check_value("host_wr_rsp.writeresponseuser", DATA_WIDTH'(exp.writeresponseuser),
                        DATA_WIDTH'(got.writeresponseuser));
        end
    endtask

    // Responses are flop outputs, so the falling edge sees them settled
    initial
    begin
        forever
        begin
            @(negedge clk);
            if (!reset && host_rd_rsp.readdatavalid)
                compare_rd_rsp(host_rd_rsp);
            if (!reset && host_wr_rsp.writeresponsevalid)
                compare_wr_rsp(host_wr_rsp);
        end
    end

    initial
    begin
        cycle_count = 0;
        while (cycle_count < MAX_CYCLES)
        begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: the tests did not finish within %0d clock cycles",
                 MAX_CYCLES);
        end_with_failure();
    end

    `include "mem_rdwr_tests.svh"

    initial
    begin
        seed = 32'hb727_7f28;
        reset = 1'b1;
        host_rd_req = '0;
        host_wr_req = '0;
        repeat (4) @(posedge clk);
        #1;
        reset = 1'b0;
        check_after_reset();
        test_single_beat();
        test_bursts();
        test_out_of_range();
        test_concurrent();
        test_back_pressure();
        $display("Simulation passed");
        $finish;
    end

endmodule

// ==== common/mem_rdwr_pkg.sv ====
// Shared widths and channel types for the split read/write memory path
package mem_rdwr_pkg;

    // Word address width on both channels
    localparam int ADDR_WIDTH = 10;

    // Data width of one beat
    localparam int DATA_WIDTH = 32;

    // One byteenable bit per data byte
    localparam int BE_WIDTH = DATA_WIDTH / 8;

    // Burst count width, bursts run from 1 to 4 beats
    localparam int BURST_WIDTH = 3;

    // User tag that rides along with a request and returns with its response
    localparam int USER_WIDTH = 4;

    // Words in the memory, any address at or above this is out of range
    localparam int MEM_DEPTH = 256;

    // Avalon response codes, SLVERR keeps the standard 2'b10 encoding
    typedef enum logic [1:0] {
        RSP_OKAY   = 2'b00,
        RSP_SLVERR = 2'b10
    } rsp_code_e;

    // The valid bit is kept as the first field, so it is the struct MSB.
    // The bridge stage relies on that to find the valid bit of any channel
    typedef struct packed {
        logic                   read;
        logic [ADDR_WIDTH-1:0]  address;
        logic [BURST_WIDTH-1:0] burstcount;
        logic [BE_WIDTH-1:0]    byteenable;
        logic [USER_WIDTH-1:0]  user;
    } rd_req_t;

    // One read beat coming back
    typedef struct packed {
        logic                  readdatavalid;
        logic [DATA_WIDTH-1:0] readdata;
        rsp_code_e             response;
        logic [USER_WIDTH-1:0] readresponseuser;
    } rd_rsp_t;

    // One write beat; address, burstcount and user only count on the first beat
    typedef struct packed {
        logic                   write;
        logic [ADDR_WIDTH-1:0]  address;
        logic [BURST_WIDTH-1:0] burstcount;
        logic [DATA_WIDTH-1:0]  writedata;
        logic [BE_WIDTH-1:0]    byteenable;
        logic [USER_WIDTH-1:0]  user;
    } wr_req_t;

    // One response per write burst
    typedef struct packed {
        logic                  writeresponsevalid;
        rsp_code_e             response;
        logic [USER_WIDTH-1:0] writeresponseuser;
    } wr_rsp_t;

endpackage

// ==== logic/avalon_bridge_stage.sv ====
`timescale 1ns/10ps

// One pipeline stage on an Avalon channel.
// The request goes through an output register backed by a one-entry skid
// register, so upstream waitrequest can come straight from a flop.
// The response path is a plain register since responses have no back-pressure.
// The valid bit of both structs is expected in the MSB
module avalon_bridge_stage
#(
    parameter type req_t = logic [1:0],
    parameter type rsp_t = logic [1:0]
)
(
    input  logic clk,
    input  logic reset,

    input  req_t up_req,
    output logic up_waitrequest,
    output rsp_t up_rsp,

    output req_t down_req,
    input  logic down_waitrequest,
    input  rsp_t down_rsp
);

    localparam int REQ_MSB = $bits(req_t) - 1;
    localparam int RSP_MSB = $bits(rsp_t) - 1;

    req_t out_q;
    logic out_valid;
    req_t skid_q;
    logic skid_valid;
    rsp_t rsp_q;
    logic rsp_valid;
    logic up_valid;
    logic up_accept;
    logic out_free;

    assign up_valid = up_req[REQ_MSB];

    // Upstream stalls only while the skid holds a beat
    assign up_waitrequest = skid_valid;
    assign up_accept = up_valid && !skid_valid;

    // The output register can load when empty or when its beat leaves this cycle
    assign out_free = !out_valid || !down_waitrequest;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            out_valid  <= 1'b0;
            skid_valid <= 1'b0;
        end
        else if (out_free)
        begin
            // Skid drains first, otherwise the new beat goes straight through
            out_valid  <= skid_valid || up_valid;
            skid_valid <= 1'b0;
        end
        else if (up_accept)
        begin
            skid_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (out_free)
            out_q <= skid_valid ? skid_q : up_req;
        // The accepted beat is parked while the output is stalled
        if (!out_free && up_accept)
            skid_q <= up_req;
    end

    always_comb
    begin
        down_req = out_q;
        down_req[REQ_MSB] = out_valid;
    end

    // The response path is one register with no flow control
    always_ff @(posedge clk)
    begin
        if (reset)
            rsp_valid <= 1'b0;
        else
            rsp_valid <= down_rsp[RSP_MSB];
        rsp_q <= down_rsp;
    end

    always_comb
    begin
        up_rsp = rsp_q;
        up_rsp[RSP_MSB] = rsp_valid;
    end

    // While the skid is full the upstream beat is not taken, so it has to stay
    // in place until waitrequest drops or the beat is lost
    a_up_hold: assert property (@(posedge clk) disable iff (reset)
        (up_valid && up_waitrequest) |=> $stable(up_req));

endmodule

// ==== logic/mem_rdwr_top.sv ====
`timescale 1ns/10ps

// Host read and write ports through the register pipeline into the memory
module mem_rdwr_top
#(
    parameter int N_REG_STAGES = 2
)
(
    input  logic clk,
    input  logic reset,

    input  mem_rdwr_pkg::rd_req_t host_rd_req,
    output logic                  host_rd_waitrequest,
    output mem_rdwr_pkg::rd_rsp_t host_rd_rsp,
    input  mem_rdwr_pkg::wr_req_t host_wr_req,
    output logic                  host_wr_waitrequest,
    output mem_rdwr_pkg::wr_rsp_t host_wr_rsp
);

    import mem_rdwr_pkg::*;

    // Memory side of the pipeline
    rd_req_t mem_rd_req;
    logic    mem_rd_waitrequest;
    rd_rsp_t mem_rd_rsp;
    wr_req_t mem_wr_req;
    logic    mem_wr_waitrequest;
    wr_rsp_t mem_wr_rsp;

    mem_rdwr_reg #(.N_REG_STAGES(N_REG_STAGES)) pipe
    (
        .clk(clk),
        .reset(reset),
        .host_rd_req(host_rd_req),
        .host_rd_waitrequest(host_rd_waitrequest),
        .host_rd_rsp(host_rd_rsp),
        .host_wr_req(host_wr_req),
        .host_wr_waitrequest(host_wr_waitrequest),
        .host_wr_rsp(host_wr_rsp),
        .mem_rd_req(mem_rd_req),
        .mem_rd_waitrequest(mem_rd_waitrequest),
        .mem_rd_rsp(mem_rd_rsp),
        .mem_wr_req(mem_wr_req),
        .mem_wr_waitrequest(mem_wr_waitrequest),
        .mem_wr_rsp(mem_wr_rsp)
    );

    rdwr_memory memory
    (
        .clk(clk),
        .reset(reset),
        .rd_req(mem_rd_req),
        .rd_waitrequest(mem_rd_waitrequest),
        .rd_rsp(mem_rd_rsp),
        .wr_req(mem_wr_req),
        .wr_waitrequest(mem_wr_waitrequest),
        .wr_rsp(mem_wr_rsp)
    );

endmodule

// ==== logic/rdwr_memory.sv ====
`timescale 1ns/10ps

// Single-port memory shared by a read channel and a write channel.
// One burst is granted at a time; on contention in idle the channels alternate
module rdwr_memory
(
    input  logic clk,
    input  logic reset,

    input  mem_rdwr_pkg::rd_req_t rd_req,
    output logic                  rd_waitrequest,
    output mem_rdwr_pkg::rd_rsp_t rd_rsp,

    input  mem_rdwr_pkg::wr_req_t wr_req,
    output logic                  wr_waitrequest,
    output mem_rdwr_pkg::wr_rsp_t wr_rsp
);

    import mem_rdwr_pkg::*;

    typedef enum logic [1:0] {
        MEM_IDLE,
        MEM_RD_BURST,
        MEM_WR_BURST
    } mem_state_e;

    mem_state_e state;
    logic last_was_rd;
    logic [DATA_WIDTH-1:0] mem [MEM_DEPTH];

    // Burst context kept after the first beat
    logic [ADDR_WIDTH-1:0]  addr_q;
    logic [BURST_WIDTH-1:0] burst_len;
    logic [BURST_WIDTH-1:0] beat_cnt;
    logic [USER_WIDTH-1:0]  user_q;
    logic                   err_q;

    logic first_beat;
    logic grant_rd;
    logic grant_wr;
    logic rd_fire;
    logic wr_fire;
    logic last_beat;
    logic in_range;
    logic [ADDR_WIDTH-1:0]  beat_addr;
    logic [BURST_WIDTH-1:0] cur_len;
    logic [BURST_WIDTH-1:0] cur_idx;
    logic [USER_WIDTH-1:0]  cur_user;
    logic [$clog2(MEM_DEPTH)-1:0] mem_idx;

    // Registered response fields
    logic                  rd_valid_q;
    logic [DATA_WIDTH-1:0] rd_data_q;
    rsp_code_e             rd_code_q;
    logic [USER_WIDTH-1:0] rd_user_q;
    logic                  wr_valid_q;
    rsp_code_e             wr_code_q;
    logic [USER_WIDTH-1:0] wr_user_q;

    assign first_beat = (state == MEM_IDLE);

    // Reads win in idle unless the last granted burst was already a read
    assign grant_rd = first_beat && rd_req.read && (!wr_req.write || !last_was_rd);
    assign grant_wr = first_beat && wr_req.write && !grant_rd;

    assign rd_waitrequest = (state == MEM_WR_BURST) || (state == MEM_RD_BURST) ||
                            (first_beat && rd_req.read && !grant_rd);
    assign wr_waitrequest = (state == MEM_RD_BURST) || (wr_req.write && grant_rd);

    // A read burst keeps producing beats once granted, writes need each beat
    assign rd_fire = grant_rd || (state == MEM_RD_BURST);
    assign wr_fire = grant_wr || (state == MEM_WR_BURST && wr_req.write);

    // First beat takes its context from the request, later beats from the latches
    always_comb
    begin
        if (first_beat)
        begin
            beat_addr = grant_rd ? rd_req.address : wr_req.address;
            cur_len   = grant_rd ? rd_req.burstcount : wr_req.burstcount;
            cur_user  = grant_rd ? rd_req.user : wr_req.user;
            cur_idx   = '0;
        end
        else
        begin
            beat_addr = addr_q;
            cur_len   = burst_len;
            cur_user  = user_q;
            cur_idx   = beat_cnt;
        end
    end

    assign last_beat = (cur_idx == cur_len - BURST_WIDTH'(1));
    assign in_range  = (beat_addr < ADDR_WIDTH'(MEM_DEPTH));
    assign mem_idx   = beat_addr[$clog2(MEM_DEPTH)-1:0];

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state       <= MEM_IDLE;
            last_was_rd <= 1'b0;
        end
        else
        begin
            case (state)
                MEM_IDLE:
                begin
                    if (grant_rd)
                    begin
                        last_was_rd <= 1'b1;
                        if (!last_beat)
                            state <= MEM_RD_BURST;
                    end
                    else if (grant_wr)
                    begin
                        last_was_rd <= 1'b0;
                        if (!last_beat)
                            state <= MEM_WR_BURST;
                    end
                end
                MEM_RD_BURST:
                    if (last_beat)
                        state <= MEM_IDLE;
                MEM_WR_BURST:
                    if (wr_fire && last_beat)
                        state <= MEM_IDLE;
                default:
                    state <= MEM_IDLE;
            endcase
        end
    end

    // Burst bookkeeping advances on every beat of either channel
    always_ff @(posedge clk)
    begin
        if (rd_fire || wr_fire)
        begin
            addr_q    <= beat_addr + ADDR_WIDTH'(1);
            burst_len <= cur_len;
            beat_cnt  <= cur_idx + BURST_WIDTH'(1);
            user_q    <= cur_user;
            // Error sticks across the burst, restarted by the first beat
            err_q     <= (!first_beat && err_q) || !in_range;
        end
    end

    // Byte-enabled array write, out-of-range beats never touch the array
    always_ff @(posedge clk)
    begin
        if (wr_fire && in_range)
        begin
            for (int b = 0; b < BE_WIDTH; b++)
            begin
                if (wr_req.byteenable[b])
                    mem[mem_idx][8*b +: 8] <= wr_req.writedata[8*b +: 8];
            end
        end
    end

    // Full words are returned on reads, whatever the read byteenable says
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            rd_valid_q <= 1'b0;
            wr_valid_q <= 1'b0;
        end
        else
        begin
            rd_valid_q <= rd_fire;
            wr_valid_q <= wr_fire && last_beat;
        end
        if (rd_fire)
        begin
            rd_data_q <= in_range ? mem[mem_idx] : '0;
            rd_code_q <= in_range ? RSP_OKAY : RSP_SLVERR;
            rd_user_q <= cur_user;
        end
        if (wr_fire && last_beat)
        begin
            wr_code_q <= ((!first_beat && err_q) || !in_range) ? RSP_SLVERR : RSP_OKAY;
            wr_user_q <= cur_user;
        end
    end

    assign rd_rsp = '{readdatavalid: rd_valid_q, readdata: rd_data_q,
                      response: rd_code_q, readresponseuser: rd_user_q};
    assign wr_rsp = '{writeresponsevalid: wr_valid_q, response: wr_code_q,
                      writeresponseuser: wr_user_q};

    // Upstream must only ever start bursts of 1 to 4 beats
    a_burst_len: assert property (@(posedge clk) disable iff (reset)
        (grant_rd || grant_wr) |-> (cur_len inside {[1:4]}));

endmodule

// ==== mem_rdwr_reg/mem_rdwr_reg.sv ====
`timescale 1ns/10ps

// Puts N_REG_STAGES bridge stages on the read channel and on the write
// channel, side by side. Stage 0 faces the host, the last stage the memory.
// Zero stages leaves both channels as plain wires
module mem_rdwr_reg
#(
    parameter int N_REG_STAGES = 2
)
(
    input  logic clk,
    input  logic reset,

    input  mem_rdwr_pkg::rd_req_t host_rd_req,
    output logic                  host_rd_waitrequest,
    output mem_rdwr_pkg::rd_rsp_t host_rd_rsp,
    input  mem_rdwr_pkg::wr_req_t host_wr_req,
    output logic                  host_wr_waitrequest,
    output mem_rdwr_pkg::wr_rsp_t host_wr_rsp,

    output mem_rdwr_pkg::rd_req_t mem_rd_req,
    input  logic                  mem_rd_waitrequest,
    input  mem_rdwr_pkg::rd_rsp_t mem_rd_rsp,
    output mem_rdwr_pkg::wr_req_t mem_wr_req,
    input  logic                  mem_wr_waitrequest,
    input  mem_rdwr_pkg::wr_rsp_t mem_wr_rsp
);

    import mem_rdwr_pkg::*;

    generate
        if (N_REG_STAGES == 0)
        begin : wires
            assign mem_rd_req = host_rd_req;
            assign host_rd_waitrequest = mem_rd_waitrequest;
            assign host_rd_rsp = mem_rd_rsp;
            assign mem_wr_req = host_wr_req;
            assign host_wr_waitrequest = mem_wr_waitrequest;
            assign host_wr_rsp = mem_wr_rsp;
        end
        else
        begin : regs
            // Index s is the upstream side of stage s, index N the memory side
            rd_req_t rd_req_pipe [N_REG_STAGES+1];
            logic    rd_wait_pipe [N_REG_STAGES+1];
            rd_rsp_t rd_rsp_pipe [N_REG_STAGES+1];
            wr_req_t wr_req_pipe [N_REG_STAGES+1];
            logic    wr_wait_pipe [N_REG_STAGES+1];
            wr_rsp_t wr_rsp_pipe [N_REG_STAGES+1];

            // Host end of the chain
            assign rd_req_pipe[0] = host_rd_req;
            assign host_rd_waitrequest = rd_wait_pipe[0];
            assign host_rd_rsp = rd_rsp_pipe[0];
            assign wr_req_pipe[0] = host_wr_req;
            assign host_wr_waitrequest = wr_wait_pipe[0];
            assign host_wr_rsp = wr_rsp_pipe[0];

            // Memory end of the chain
            assign mem_rd_req = rd_req_pipe[N_REG_STAGES];
            assign rd_wait_pipe[N_REG_STAGES] = mem_rd_waitrequest;
            assign rd_rsp_pipe[N_REG_STAGES] = mem_rd_rsp;
            assign mem_wr_req = wr_req_pipe[N_REG_STAGES];
            assign wr_wait_pipe[N_REG_STAGES] = mem_wr_waitrequest;
            assign wr_rsp_pipe[N_REG_STAGES] = mem_wr_rsp;

            for (genvar s = 0; s < N_REG_STAGES; s++)
            begin : p
                avalon_bridge_stage #(.req_t(rd_req_t), .rsp_t(rd_rsp_t)) bridge_rd
                (
                    .clk(clk),
                    .reset(reset),
                    .up_req(rd_req_pipe[s]),
                    .up_waitrequest(rd_wait_pipe[s]),
                    .up_rsp(rd_rsp_pipe[s]),
                    .down_req(rd_req_pipe[s+1]),
                    .down_waitrequest(rd_wait_pipe[s+1]),
                    .down_rsp(rd_rsp_pipe[s+1])
                );

                // The write channel has its own stage with its own skid and response register
                avalon_bridge_stage #(.req_t(wr_req_t), .rsp_t(wr_rsp_t)) bridge_wr
                (
                    .clk(clk),
                    .reset(reset),
                    .up_req(wr_req_pipe[s]),
                    .up_waitrequest(wr_wait_pipe[s]),
                    .up_rsp(wr_rsp_pipe[s]),
                    .down_req(wr_req_pipe[s+1]),
                    .down_waitrequest(wr_wait_pipe[s+1]),
                    .down_rsp(wr_rsp_pipe[s+1])
                );
            end
        end
    endgenerate

endmodule

// ==== sim.f ====
+incdir+bench
common/mem_rdwr_pkg.sv
logic/avalon_bridge_stage.sv
mem_rdwr_reg/mem_rdwr_reg.sv
logic/rdwr_memory.sv
logic/mem_rdwr_top.sv
bench/mem_rdwr_tb.sv
